// ==== Makefile ====
# Verilator build and run for the immediate expander testbench

TOP = immexp_zfind_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f immexp_zfind.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// ==== bench/immexp_zfind_tb.sv ====
`timescale 1ns/100ps
/*
 * Testbench for the immediate expander with zero-finder
 * Directed and random stimulus checked against a cycle model
 */
module immexp_zfind_tb;
    import rv_isa_pkg::*;
    import datapath_pkg::*;

    // ==============================
    // Run length
    // ==============================
    localparam int CLK_PERIOD = 40;  // ns
    localparam int N_RESET    = 5;
    localparam int N_IDLE     = 4;   // ena_q low after reset
    localparam int N_PASS     = 100;
    localparam int N_DIRECTED = 44;  // 11 opcodes, 2 signs, 2 each
    localparam int N_ILLEGAL  = 40;
    localparam int N_CLEAR    = 60;
    localparam int N_HOLD     = 61;  // Includes the preload
    localparam int N_RANDOM   = 300;
    localparam int N_DRAIN    = 3;
    localparam int TOTAL_CYCLES = N_RESET + N_IDLE + N_PASS + N_DIRECTED + N_ILLEGAL
                                + N_CLEAR + N_HOLD + N_RANDOM + N_DRAIN;
    localparam int MARGIN     = 50;

    logic   clk = 1'b0;
    logic   rst_n;
    word_t  alu_result;
    instr_t instr;
    logic   imm_expand;
    logic   clear_q;
    logic   core_running;
    logic   ena_q;
    word_t  adr;
    logic   result_nonzero;

    integer seed = 32'hf7d1_9c7c;
    int     error_count = 0;
    string  test_name;             // Tag travelling with the inputs

    // Model state, valid after the next rising edge
    word_t  model_adr;
    logic   model_nz;
    logic   model_valid = 1'b0;
    string  model_test = "";

    // Major opcodes of RV32I plus the custom I-type slot
    logic [4:0] defined_ops [11] = '{5'b00000, 5'b00010, 5'b00100, 5'b00101,
                                     5'b01000, 5'b01100, 5'b01101, 5'b11000,
                                     5'b11001, 5'b11011, 5'b11100};

    immexp_zfind immexp_zfind_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .alu_result     (alu_result),
        .instr          (instr),
        .imm_expand     (imm_expand),
        .clear_q        (clear_q),
        .core_running   (core_running),
        .ena_q          (ena_q),
        .adr            (adr),
        .result_nonzero (result_nonzero)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // ==============================
    // Reference model
    // ==============================
    function automatic word_t expected_operand(input instr_t i, input word_t alu,
                                               input logic expand);
        word_t imm_i;
        word_t imm_s;
        word_t imm_b;
        word_t imm_u;
        word_t imm_j;
        imm_i = {{20{i[31]}}, i[31:20]};                               // Spec layout
        imm_s = {{20{i[31]}}, i[31:25], i[11:7]};
        imm_b = {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
        imm_u = {i[31:12], 12'h000};
        imm_j = {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
        if (!expand) begin
            return alu;                                                // Not decoding
        end
        case (i[6:2])
            5'b00000, 5'b00100, 5'b11001,
            5'b01100, 5'b11100, 5'b00010: return imm_i;                // Incl. custom
            5'b01000:                     return imm_s;
            5'b11000:                     return imm_b;
            5'b00101, 5'b01101:           return imm_u;
            5'b11011:                     return imm_j;
            default:                      return '0;                   // Illegal
        endcase
    endfunction

    function automatic logic is_defined(input logic [4:0] op);
        for (int k = 0; k < 11; k++) begin
            if (defined_ops[k] == op) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // ==============================
    // Stimulus helpers
    // ==============================
    function automatic int pick(input int den);
        return ($random(seed) & 32'h7fff_ffff) % den; // Non-negative draw
    endfunction

    function automatic logic chance(input int num, input int den);
        return pick(den) < num;
    endfunction

    function automatic logic [4:0] illegal_op();
        logic [4:0] op;
        do begin
            op = 5'($random(seed));
        end while (is_defined(op));
        return op;
    endfunction

    function automatic instr_t make_instr(input logic [4:0] op, input logic sign);
        instr_t r;
        r       = $random(seed);
        r[31]   = sign;
        r[6:2]  = op;
        r[1:0]  = 2'b11;                 // 32-bit encoding
        return r;
    endfunction

    function automatic word_t random_alu();
        word_t v;
        v = $random(seed);
        if (pick(8) == 0) begin
            v = '0;                      // Feed the zero-finder
        end
        return v;
    endfunction

    task automatic drive(input string name, input instr_t i, input word_t alu,
                         input logic exp, input logic ena, input logic clr,
                         input logic run);
        @(posedge clk);
        test_name    <= name;
        instr        <= i;
        alu_result   <= alu;
        imm_expand   <= exp;
        ena_q        <= ena;
        clear_q      <= clr;
        core_running <= run;
    endtask

    // ==============================
    // Compare tasks
    // ==============================
    task automatic check_adr(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("mismatch %s: adr expected %h, actual %h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "adr compare failed");
        end
    endtask

    task automatic check_nonzero(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            error_count++;
            $display("mismatch %s: result_nonzero expected %b, actual %b",
                     name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "result_nonzero compare failed");
        end
    endtask

    // Check mid-cycle, then predict the next edge
    always @(negedge clk) begin
        if (model_valid) begin
            check_adr(model_test, model_adr, adr);
            check_nonzero(model_test, model_nz, result_nonzero);
        end
        if (!rst_n) begin
            model_adr   = '0;
            model_nz    = 1'b0;
            model_valid = 1'b1;
        end else if (ena_q) begin
            if (clear_q || !core_running) begin
                model_adr = '0;          // Clear beats the load
                model_nz  = 1'b0;
            end else begin
                model_adr = expected_operand(instr, alu_result, imm_expand);
                model_nz  = (alu_result != '0);
            end
        end
        model_test = test_name;
    end

    // ==============================
    // Watchdog
    // ==============================
    initial begin
        #((TOTAL_CYCLES + MARGIN) * CLK_PERIOD);
        $display("timeout, stimulus did not finish within %0d cycles", TOTAL_CYCLES + MARGIN);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        rst_n        <= 1'b0;
        test_name    <= "reset";
        instr        <= '0;
        alu_result   <= '0;
        imm_expand   <= 1'b0;
        clear_q      <= 1'b0;
        core_running <= 1'b0;
        ena_q        <= 1'b0;
        repeat (N_RESET) @(posedge clk);
        rst_n <= 1'b1;

        for (int n = 0; n < N_IDLE; n++) begin
            drive("idle_after_reset", make_instr(5'b00100, 1'b1), random_alu(), 1'b1,
                  1'b0, 1'b0, 1'b1);
        end
        for (int n = 0; n < N_PASS; n++) begin
            drive("pass_through", make_instr(defined_ops[pick(11)], chance(1, 2)),
                  random_alu(), 1'b0, 1'b1, 1'b0, 1'b1);
        end
        foreach (defined_ops[k]) begin           // Both signs per opcode
            for (int s = 0; s < 4; s++) begin
                drive("directed_opcode", make_instr(defined_ops[k], s[0]), random_alu(),
                      1'b1, 1'b1, 1'b0, 1'b1);
            end
        end
        for (int n = 0; n < N_ILLEGAL; n++) begin
            drive("illegal_opcode", make_instr(illegal_op(), chance(1, 2)), random_alu(),
                  1'b1, 1'b1, 1'b0, 1'b1);
        end
        for (int n = 0; n < N_CLEAR; n++) begin
            logic clr;
            clr = chance(1, 2);
            drive("clear", make_instr(defined_ops[pick(11)], chance(1, 2)), random_alu(),
                  chance(1, 2), 1'b1, clr, clr ? chance(1, 2) : 1'b0);
        end
        drive("hold_preload", make_instr(5'b01100, 1'b0), 32'hdead_beef, 1'b0,
              1'b1, 1'b0, 1'b1);                 // Nonzero value to hold
        for (int n = 0; n < N_HOLD - 1; n++) begin
            drive("hold", make_instr(pick(2) ? illegal_op() : defined_ops[pick(11)],
                  chance(1, 2)), random_alu(), chance(1, 2), 1'b0, chance(1, 2),
                  chance(1, 2));
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            drive("random_mix", make_instr(chance(1, 8) ? illegal_op() : defined_ops[pick(11)],
                  chance(1, 2)), random_alu(), chance(1, 2), chance(3, 4), chance(1, 8),
                  chance(7, 8));
        end
        repeat (N_DRAIN) @(posedge clk);         // Let the last checks run

        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/adr_register.sv ====
`timescale 1ns/100ps
/*
 * Address/working register with zero-finder
 * Loads the operand on enabled edges and records whether the ALU result was nonzero
 */
module adr_register (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ena_q,          // Load enable
    input  logic                clear_q,        // Clear request
    input  logic                core_running,   // Low keeps both registers clear
    input  datapath_pkg::word_t operand,        // Expanded operand
    input  datapath_pkg::word_t alu_result,     // Zero-finder input
    output datapath_pkg::word_t adr,            // Working and I/O address register
    output logic                result_nonzero  // Low when alu_result was zero
);

    logic clear_cond;  // Either source of a clear
    logic alu_nonzero; // Zero-finder output

    assign clear_cond  = clear_q || !core_running;
    assign alu_nonzero = |alu_result; // OR-reduce the whole word

    // ==============================
    // Registers
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            adr            <= '0;
            result_nonzero <= 1'b0;
        end else if (ena_q) begin
            if (clear_cond) begin
                adr            <= '0; // Clear wins over the load
                result_nonzero <= 1'b0;
            end else begin
                adr            <= operand;
                result_nonzero <= alu_nonzero;
            end
        end
    end

    // ==============================
    // Checks
    // ==============================
    // A clear on an enabled edge zeroes both registers
    a_clear_zeroes : assert property (
        @(posedge clk) disable iff (!rst_n)
        ena_q && clear_cond |=> (adr == '0) && !result_nonzero
    ) else $error("adr_register: clear did not zero adr");

    // Without ena_q the register holds
    a_hold_when_idle : assert property (
        @(posedge clk) disable iff (!rst_n)
        !ena_q |=> $stable(adr) && $stable(result_nonzero)
    ) else $error("adr_register: adr changed while ena_q low");

endmodule

// ==== hdl/datapath_pkg.sv ====
/*
 * Datapath word definitions
 * Shared by the expander, the adr register and the top level
 */
package datapath_pkg;

    // ==============================
    // Data word
    // ==============================
    // Immediates are defined as 32 bits,
    // so the datapath width is fixed here
    localparam int XLEN = 32; // Data word width

    // ALU result, expanded operand and adr
    typedef logic [XLEN-1:0] word_t;

endpackage

// ==== hdl/imm_expander.sv ====
`timescale 1ns/100ps
/*
 * Immediate expander
 * Sign-extends the immediate of the selected format or forwards the ALU result
 */
module imm_expander (
    input  rv_isa_pkg::imm_fmt_e fmt,        // From the format decoder
    input  rv_isa_pkg::instr_t   instr,      // Instruction word
    input  datapath_pkg::word_t  alu_result, // Used outside decode
    output datapath_pkg::word_t  operand     // To the adr register
);
    import rv_isa_pkg::*;
    import datapath_pkg::*;

    logic sign; // Top bit of every signed immediate

    assign sign = instr[IMM_SIGN];

    // ==============================
    // Immediate assembly
    // ==============================
    always_comb begin
        case (fmt)
            FMT_I: begin
                // Sign then 30..20
                operand = {{(XLEN-11){sign}}, instr[30:20]};
            end
            FMT_S: begin
                // Sign then 30..25 and 11..7
                operand = {{(XLEN-11){sign}}, instr[30:25], instr[11:7]};
            end
            FMT_B: begin
                // Bit 7 lands in position 11
                operand = {{(XLEN-12){sign}}, instr[7], instr[30:25],
                           instr[11:8], 1'b0};
            end
            FMT_U: begin
                operand = {instr[31:12], 12'b0}; // Low 12 bits cleared
            end
            FMT_J: begin
                // Bits 19..12 stay in place, bit 20 drops to 11
                operand = {{(XLEN-20){sign}}, instr[19:12], instr[20],
                           instr[30:21], 1'b0};
            end
            FMT_PASS: begin
                operand = alu_result; // Not a decode cycle
            end
            default: begin
                operand = '0; // Illegal opcode and unused code
            end
        endcase
    end

endmodule

// ==== hdl/imm_format_decoder.sv ====
`timescale 1ns/100ps
/*
 * Immediate format decoder
 * Maps the major opcode to an immediate format during decode
 */
module imm_format_decoder (
    input  logic                   imm_expand, // High in the decode cycle
    input  rv_isa_pkg::rv_opcode_e opcode,     // Instruction bits 6..2
    output rv_isa_pkg::imm_fmt_e   fmt         // Operand source for expander
);
    import rv_isa_pkg::*;

    // ==============================
    // Format selection
    // ==============================
    always_comb begin
        if (!imm_expand) begin
            fmt = FMT_PASS; // ALU result goes straight through
        end else begin
            case (opcode)
                LOAD: begin
                    fmt = FMT_I; // Load offset
                end
                OP_IMM: begin
                    fmt = FMT_I; // ALU immediate
                end
                JALR: begin
                    fmt = FMT_I; // Jump target offset
                end
                OP: begin
                    fmt = FMT_I; // No immediate, value unused
                end
                SYSTEM: begin
                    fmt = FMT_I; // CSR address field
                end
                CUSTOM_IJ: begin
                    fmt = FMT_I; // Custom op shares I layout
                end
                STORE: begin
                    fmt = FMT_S; // Split store offset
                end
                BRANCH: begin
                    fmt = FMT_B; // Halfword branch offset
                end
                AUIPC: begin
                    fmt = FMT_U; // Upper immediate
                end
                LUI: begin
                    fmt = FMT_U;
                end
                JAL: begin
                    fmt = FMT_J; // 21-bit jump offset
                end
                default: begin
                    fmt = FMT_ILLEGAL; // Anything else is not ours
                end
            endcase
        end
    end

endmodule

// ==== hdl/immexp_zfind.sv ====
`timescale 1ns/100ps
/*
 * Immediate operand expander with zero-finder and adr register
 * Decoder and expander are combinational, the register adds one cycle
 */
module immexp_zfind (
    input  logic                clk,
    input  logic                rst_n,
    input  datapath_pkg::word_t alu_result,     // ALU output
    input  rv_isa_pkg::instr_t  instr,          // Current instruction
    input  logic                imm_expand,     // Decode cycle
    input  logic                clear_q,        // Clear adr on enabled edge
    input  logic                core_running,   // Low holds adr clear
    input  logic                ena_q,          // Update adr
    output datapath_pkg::word_t adr,
    output logic                result_nonzero  // Registered nonzero flag
);
    import rv_isa_pkg::*;
    import datapath_pkg::*;

    rv_opcode_e opcode;  // Major opcode field
    imm_fmt_e   fmt;     // Decoder to expander
    word_t      operand; // Expander to register

    assign opcode = rv_opcode_e'(instr[OPCODE_MSB:OPCODE_LSB]);

    // ==============================
    // Datapath
    // ==============================
    imm_format_decoder imm_format_decoder_inst (
        .imm_expand (imm_expand),
        .opcode     (opcode),
        .fmt        (fmt)
    );

    imm_expander imm_expander_inst (
        .fmt        (fmt),
        .instr      (instr),
        .alu_result (alu_result),
        .operand    (operand)
    );

    adr_register adr_register_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .ena_q          (ena_q),
        .clear_q        (clear_q),
        .core_running   (core_running),
        .operand        (operand),
        .alu_result     (alu_result),
        .adr            (adr),
        .result_nonzero (result_nonzero)
    );

endmodule

// ==== hdl/rv_isa_pkg.sv ====
/*
 * RISC-V instruction set encodings for the immediate expander
 * Major opcodes, immediate formats and instruction field positions
 */
package rv_isa_pkg;

    // ==============================
    // Instruction word layout
    // ==============================
    localparam int INSTR_W    = 32;                         // Base 32-bit encodings only
    localparam int OPCODE_LSB = 2;                          // Bits 1..0 are always 11
    localparam int OPCODE_MSB = 6;
    localparam int OPCODE_W   = OPCODE_MSB - OPCODE_LSB + 1; // Major opcode field
    localparam int IMM_SIGN   = 31;                         // Sign bit of every immediate

    typedef logic [INSTR_W-1:0] instr_t; // Raw instruction word

    // ==============================
    // Major opcodes, bits 6..2
    // ==============================
    typedef enum logic [OPCODE_W-1:0] {
        LOAD      = 5'b00000, // Loads
        CUSTOM_IJ = 5'b00010, // Custom ij, decodes as I
        OP_IMM    = 5'b00100, // Reg-imm ALU ops
        AUIPC     = 5'b00101, // Add upper imm to pc
        STORE     = 5'b01000, // Stores
        OP        = 5'b01100, // Reg-reg ALU ops
        LUI       = 5'b01101, // Load upper imm
        BRANCH    = 5'b11000, // Conditional branches
        JALR      = 5'b11001, // Indirect jump
        JAL       = 5'b11011, // Direct jump
        SYSTEM    = 5'b11100  // CSR and environment
    } rv_opcode_e;

    // ==============================
    // Operand source selection
    // ==============================
    // Pass-through keeps the all-ones code
    // and 3'b110 is unused
    typedef enum logic [2:0] {
        FMT_U       = 3'b000, // Upper 20 bits
        FMT_J       = 3'b001, // Jump offset
        FMT_B       = 3'b010, // Branch offset
        FMT_ILLEGAL = 3'b011, // Unknown opcode in decode
        FMT_S       = 3'b100, // Store offset
        FMT_I       = 3'b101, // 12-bit signed immediate
        FMT_PASS    = 3'b111  // Not a decode cycle
    } imm_fmt_e;

endpackage

// ==== immexp_zfind.f ====
hdl/rv_isa_pkg.sv
hdl/datapath_pkg.sv
hdl/imm_format_decoder.sv
hdl/imm_expander.sv
hdl/adr_register.sv
hdl/immexp_zfind.sv
bench/immexp_zfind_tb.sv
